// File: list.f
+incdir+include
rtl/gpiopwm_pkg.sv
rtl/key_debounce.sv
rtl/duty_select.sv
rtl/phase_accum.sv
rtl/pwm_compare.sv
rtl/gpiopwm_top.sv
sim/gpiopwm_asserts.sv
sim/gpiopwm_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the PWM testbench with Verilator
# The run passes only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vgpiopwm_tb

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module gpiopwm_tb -Mdir obj_dir -f list.f
then
	echo "verilator build failed"
	exit 1
fi

# Allow several assertion errors so the testbench can report them itself
"$BIN" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]
then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^>>> PASS$' "$LOG"
then
	exit 0
fi

echo "pass line not found in $LOG"
exit 1

// File: sim/gpiopwm_tb.sv
// Uses a 64-cycle PWM period and 16-cycle debounce. Duty is measured only over windows with en_sig high
`timescale 1ns/1ps
`include "gpiopwm_macros.svh"

module gpiopwm_tb;

	// 2^26 step gives a 64-cycle period
	localparam logic [31:0] STEP     = 32'h0400_0000;
	localparam int          DEBOUNCE = 16;
	localparam int          PERIOD   = int'(64'h1_0000_0000 / 64'(STEP));
	// About 40 PWM periods plus debouncing, with margin
	localparam int          MAX_CYCLES = 4000;

	logic       CLOCK = 1'b0;
	logic       RST_n;
	logic [2:0] option_key;
	logic       en_sig;
	logic       gpio_pwm;

	int          cycles = 0;
	int unsigned rng_state;

	gpiopwm_top
	#(
		.STEP            (STEP),
		.DEBOUNCE_CYCLES (DEBOUNCE)
	)
	u_dut
	(
		.CLOCK      (CLOCK),
		.RST_n      (RST_n),
		.option_key (option_key),
		.en_sig     (en_sig),
		.gpio_pwm   (gpio_pwm)
	);

	// 50 MHz
	initial
	begin
		forever #10 CLOCK = ~CLOCK;
	end

	// --------------------
	// Helpers
	// --------------------

	// LCG, upper bits are the better ones
	function automatic int unsigned next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state >> 16;
	endfunction

	// High share is 2^32 minus threshold, scaled to one period and rounded
	function automatic int expected_high(input logic [31:0] thr);
		logic [63:0] span;
		span = 64'h1_0000_0000 - 64'(thr);
		return int'((span * 64'(PERIOD) + 64'h8000_0000) >> 32);
	endfunction

	task automatic idle(input int n);
		repeat (n) @(negedge CLOCK);
	endtask

	// Hold long enough to pass debounce, then release just as long
	task automatic press_keys(input logic [2:0] keys);
		option_key = keys;
		idle(DEBOUNCE + 8);
		option_key = 3'b000;
		idle(DEBOUNCE + 8);
	endtask

	// Bounces shorter than the debounce length on random keys
	task automatic send_glitches(input int count);
		int len;
		int key;
		for (int i = 0; i < count; i++)
		begin
			len = 1 + int'(next_rand() % (DEBOUNCE - 1));
			key = int'(next_rand() % 3);
			option_key[key] = 1'b1;
			idle(len);
			option_key = 3'b000;
			idle(2 + int'(next_rand() % 6));
		end
		idle(DEBOUNCE + 8);
	endtask

	// Drop enable at random points of the period
	task automatic freeze_output(input int count);
		for (int i = 0; i < count; i++)
		begin
			idle(int'(next_rand() % PERIOD));
			en_sig = 1'b0;
			idle(6 + int'(next_rand() % 8));
			en_sig = 1'b1;
		end
	endtask

	// Count high cycles over one full period
	task automatic check_duty(input logic [31:0] thr);
		int high;
		int exp_high;
		high = 0;
		exp_high = expected_high(thr);
		idle(4);
		repeat (PERIOD)
		begin
			@(negedge CLOCK);
			if (gpio_pwm)
				high++;
		end
		assert ((high >= exp_high - 1) && (high <= exp_high + 1))
		else
		begin
			$display("error at time %0t: gpio_pwm high cycles expected %0d, got %0d",
				$time, exp_high, high);
			$display(">>> FAIL");
			$fatal(1, "duty measurement out of range");
		end
	endtask

	// --------------------
	// Watchdogs
	// --------------------

	always @(posedge CLOCK)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
			$display(">>> FAIL");
			$fatal(1, "timeout");
		end
	end

	// Bound assertions raise a flag on failure
	always @(negedge CLOCK)
	begin
		if (u_dut.u_asserts.any_fail)
		begin
			$display("a bound assertion on the DUT failed, see its message above");
			$display(">>> FAIL");
			$fatal(1, "assertion failure");
		end
	end

	// --------------------
	// Stimulus
	// --------------------

	initial
	begin
		RST_n      = 1'b0;
		option_key = 3'b000;
		en_sig     = 1'b1;
		rng_state  = 32'd50770;
		idle(8);
		RST_n = 1'b1;
		// Reset choice is half
		check_duty(`GPIOPWM_THR_50);
		// Right key
		press_keys(3'b100);
		check_duty(`GPIOPWM_THR_10);
		// Short bounces change nothing
		send_glitches(8);
		check_duty(`GPIOPWM_THR_10);
		// Left key
		press_keys(3'b010);
		check_duty(`GPIOPWM_THR_80);
		// Right wins over middle
		press_keys(3'b101);
		check_duty(`GPIOPWM_THR_10);
		press_keys(3'b001);
		check_duty(`GPIOPWM_THR_50);
		// Enable gaps, checked by the hold assertion
		freeze_output(6);
		check_duty(`GPIOPWM_THR_50);
		// Let the assertions sample the last cycles
		idle(4);
		if (u_dut.u_asserts.any_fail)
		begin
			$display("a bound assertion on the DUT failed, see its message above");
			$display(">>> FAIL");
			$fatal(1, "assertion failure");
		end
		else
		begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// File: sim/gpiopwm_asserts.sv
// Bound to gpiopwm_top. Rise spacing is only checked once the duty choice has held for two periods
`timescale 1ns/1ps
`include "gpiopwm_macros.svh"

module gpiopwm_asserts
#(
	parameter gpiopwm_pkg::phase_t STEP = `GPIOPWM_STEP_DEFAULT
)
(
	input logic                      CLOCK,
	input logic                      RST_n,
	input logic                      en_sig,
	input logic                      gpio_pwm,
	input logic [`GPIOPWM_KEY_W-1:0] key_press,
	input gpiopwm_pkg::duty_sel_e    duty_sel
);

	import gpiopwm_pkg::*;

	// Enabled clocks per PWM period
	localparam int PERIOD = int'(64'h1_0000_0000 / 64'(STEP));

	// One sticky flag per assertion
	logic hold_fail  = 1'b0;
	logic reset_fail = 1'b0;
	logic rise_fail  = 1'b0;
	logic press_fail = 1'b0;
	logic any_fail;

	logic      pwm_q;
	duty_sel_e sel_q;
	int        rise_gap;
	int        settle_cnt;

	assign any_fail = hold_fail | reset_fail | rise_fail | press_fail;

	// --------------------
	// Helper state
	// --------------------

	// Enabled clocks since the last rise, and since the last duty change
	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			pwm_q      <= 1'b0;
			sel_q      <= DUTY_50;
			rise_gap   <= 0;
			settle_cnt <= 0;
		end
		else
		begin
			pwm_q <= gpio_pwm;
			sel_q <= duty_sel;
			if (gpio_pwm && !pwm_q)
				rise_gap <= en_sig ? 1 : 0;
			else if (en_sig && rise_gap < 2 * PERIOD)
				rise_gap <= rise_gap + 1;
			if (duty_sel != sel_q)
				settle_cnt <= 0;
			else if (en_sig && settle_cnt < 2 * PERIOD)
				settle_cnt <= settle_cnt + 1;
		end
	end

	// --------------------
	// Output rules
	// --------------------

	// Two disabled clocks in a row freeze the pin
	a_hold: assert property (@(posedge CLOCK) disable iff (!RST_n)
		(!$past(en_sig) && !$past(en_sig, 2)) |-> $stable(gpio_pwm))
	else
	begin
		$error("gpio_pwm changed while en_sig was low");
		hold_fail = 1'b1;
	end

	// Both output flops start cleared
	a_reset_low: assert property (@(posedge CLOCK)
		$rose(RST_n) |-> !gpio_pwm ##1 !gpio_pwm)
	else
	begin
		$error("gpio_pwm was high within two cycles of reset release");
		reset_fail = 1'b1;
	end

	// At most one rise per period of enabled clocks
	a_rise_spacing: assert property (@(posedge CLOCK) disable iff (!RST_n)
		($rose(gpio_pwm) && settle_cnt >= 2 * PERIOD) |-> (rise_gap >= PERIOD))
	else
	begin
		$error("gpio_pwm rose again after only %0d enabled cycles", rise_gap);
		rise_fail = 1'b1;
	end

	// --------------------
	// Key path rules
	// --------------------

	// Press pulses last one clock
	a_press_pulse: assert property (@(posedge CLOCK) disable iff (!RST_n)
		(key_press & $past(key_press)) == '0)
	else
	begin
		$error("key_press stayed high for more than one cycle");
		press_fail = 1'b1;
	end

endmodule

bind gpiopwm_top gpiopwm_asserts
#(
	.STEP (STEP)
)
u_asserts
(
	.CLOCK     (CLOCK),
	.RST_n     (RST_n),
	.en_sig    (en_sig),
	.gpio_pwm  (gpio_pwm),
	.key_press (key_press),
	.duty_sel  (duty_sel)
);

// File: rtl/gpiopwm_top.sv
// Keys are not gated by en_sig. Key to duty change takes about DEBOUNCE_CYCLES plus four clocks
`timescale 1ns/1ps
`include "gpiopwm_macros.svh"

module gpiopwm_top
#(
	parameter gpiopwm_pkg::phase_t STEP            = `GPIOPWM_STEP_DEFAULT,
	parameter int                  DEBOUNCE_CYCLES = `GPIOPWM_DEBOUNCE_DEFAULT
)
(
	input  logic                      CLOCK,
	input  logic                      RST_n,
	// Bit 2 right, bit 1 left, bit 0 middle
	input  logic [`GPIOPWM_KEY_W-1:0] option_key,
	input  logic                      en_sig,
	output logic                      gpio_pwm
);

	import gpiopwm_pkg::*;

	logic [`GPIOPWM_KEY_W-1:0] key_press;
	duty_sel_e                 duty_sel;
	phase_t                    phase;

	// --------------------
	// Key path
	// --------------------

	// Debounced press pulses
	key_debounce
	#(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	)
	u_key_debounce
	(
		.CLOCK      (CLOCK),
		.RST_n      (RST_n),
		.option_key (option_key),
		.key_press  (key_press)
	);

	// Current duty choice
	duty_select u_duty_select
	(
		.CLOCK     (CLOCK),
		.RST_n     (RST_n),
		.key_press (key_press),
		.duty_sel  (duty_sel)
	);

	// --------------------
	// PWM path
	// --------------------

	// DDS phase
	phase_accum
	#(
		.STEP (STEP)
	)
	u_phase_accum
	(
		.CLOCK  (CLOCK),
		.RST_n  (RST_n),
		.en_sig (en_sig),
		.phase  (phase)
	);

	// Threshold compare and output flops
	pwm_compare u_pwm_compare
	(
		.CLOCK    (CLOCK),
		.RST_n    (RST_n),
		.en_sig   (en_sig),
		.duty_sel (duty_sel),
		.phase    (phase),
		.gpio_pwm (gpio_pwm)
	);

endmodule

// File: rtl/pwm_compare.sv
// Output is high while phase >= threshold, so duty names give the low share. Output lags phase by two enabled clocks
`timescale 1ns/1ps
`include "gpiopwm_macros.svh"

module pwm_compare
(
	input  logic                   CLOCK,
	input  logic                   RST_n,
	input  logic                   en_sig,
	input  gpiopwm_pkg::duty_sel_e duty_sel,
	input  gpiopwm_pkg::phase_t    phase,
	output logic                   gpio_pwm
);

	import gpiopwm_pkg::*;

	phase_t thr;
	logic   cmp_q;
	logic   out_q;

	// --------------------
	// Threshold decode
	// --------------------

	always_comb
	begin
		case (duty_sel)
			DUTY_10:
				thr = `GPIOPWM_THR_10;
			DUTY_80:
				thr = `GPIOPWM_THR_80;
			// Unused code falls back to half
			default:
				thr = `GPIOPWM_THR_50;
		endcase
	end

	// --------------------
	// Compare and output registers
	// --------------------

	// First stage holds the raw compare result
	// Second stage gives a clean output flop
	// Both freeze with en_sig low, so the pin holds its level
	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			cmp_q <= 1'b0;
			out_q <= 1'b0;
		end
		else if (en_sig)
		begin
			cmp_q <= (phase >= thr);
			out_q <= cmp_q;
		end
	end

	assign gpio_pwm = out_q;

endmodule

// File: rtl/phase_accum.sv
// Step is fixed per build. The phase wraps freely and only advances while en_sig is high
`timescale 1ns/1ps
`include "gpiopwm_macros.svh"

module phase_accum
#(
	// fo = fc * STEP / 2^32
	parameter gpiopwm_pkg::phase_t STEP = `GPIOPWM_STEP_DEFAULT
)
(
	input  logic                CLOCK,
	input  logic                RST_n,
	input  logic                en_sig,
	output gpiopwm_pkg::phase_t phase
);

	// --------------------
	// Accumulator
	// --------------------

	// Overflow is the period boundary
	// Carry out is dropped on purpose, the wrap is the DDS action
	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
			phase <= '0;
		// Freeze while disabled
		else if (en_sig)
			phase <= phase + STEP;
	end

endmodule

// File: rtl/duty_select.sv
// Inputs are one-cycle press pulses. Right beats left and left beats middle when pulses coincide
`timescale 1ns/1ps
`include "gpiopwm_macros.svh"

module duty_select
(
	input  logic                      CLOCK,
	input  logic                      RST_n,
	input  logic [`GPIOPWM_KEY_W-1:0] key_press,
	output gpiopwm_pkg::duty_sel_e    duty_sel
);

	import gpiopwm_pkg::*;

	// Key bit positions
	localparam int KEY_RIGHT = 2;
	localparam int KEY_LEFT  = 1;
	localparam int KEY_MID   = 0;

	// --------------------
	// Selection register
	// --------------------

	// Holds its value between presses
	// Reset choice is the even split
	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
			duty_sel <= DUTY_50;
		// Right key, mostly high output
		else if (key_press[KEY_RIGHT])
			duty_sel <= DUTY_10;
		// Left key, mostly low output
		else if (key_press[KEY_LEFT])
			duty_sel <= DUTY_80;
		// Middle key back to half
		else if (key_press[KEY_MID])
			duty_sel <= DUTY_50;
	end

endmodule

// File: rtl/key_debounce.sv
// Keys are asynchronous levels, high when pressed. A level must stay steady for DEBOUNCE_CYCLES clocks to count
`timescale 1ns/1ps
`include "gpiopwm_macros.svh"

module key_debounce
#(
	parameter int DEBOUNCE_CYCLES = `GPIOPWM_DEBOUNCE_DEFAULT
)
(
	input  logic                      CLOCK,
	input  logic                      RST_n,
	input  logic [`GPIOPWM_KEY_W-1:0] option_key,
	output logic [`GPIOPWM_KEY_W-1:0] key_press
);

	// Counter wide enough to reach the hold limit
	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

	logic [`GPIOPWM_KEY_W-1:0] key_meta;
	logic [`GPIOPWM_KEY_W-1:0] key_sync;
	logic [`GPIOPWM_KEY_W-1:0] key_stable;
	logic [`GPIOPWM_KEY_W-1:0] key_flip;
	logic [CNT_W-1:0]          hold_cnt [`GPIOPWM_KEY_W];

	// --------------------
	// Synchronizer
	// --------------------

	// Two flops per key against metastability
	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			key_meta <= '0;
			key_sync <= '0;
		end
		else
		begin
			key_meta <= option_key;
			key_sync <= key_meta;
		end
	end

	// --------------------
	// Hold counters
	// --------------------

	// Stable level flips once the new level has been seen for the full hold time
	always_comb
	begin
		for (int i = 0; i < `GPIOPWM_KEY_W; i++)
			key_flip[i] = (key_sync[i] != key_stable[i]) && (hold_cnt[i] == CNT_LAST);
	end

	// Counter restarts while input matches the stable level, so a glitch never accumulates
	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			for (int i = 0; i < `GPIOPWM_KEY_W; i++)
				hold_cnt[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < `GPIOPWM_KEY_W; i++)
			begin
				if (key_sync[i] == key_stable[i] || key_flip[i])
					hold_cnt[i] <= '0;
				else
					hold_cnt[i] <= hold_cnt[i] + 1'b1;
			end
		end
	end

	// --------------------
	// Stable level and press pulse
	// --------------------

	// Pulse only on the released to pressed flip, one cycle wide
	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			key_stable <= '0;
			key_press  <= '0;
		end
		else
		begin
			key_stable <= key_stable ^ key_flip;
			key_press  <= key_flip & key_sync;
		end
	end

endmodule

// File: rtl/gpiopwm_pkg.sv
// Shared types for the PWM core. The phase width comes from the macros header, which must be on the include path
`include "gpiopwm_macros.svh"

package gpiopwm_pkg;

	// --------------------
	// Phase word
	// --------------------

	// Unsigned accumulator value, wraps modulo 2^32
	typedef logic [`GPIOPWM_PHASE_W-1:0] phase_t;

	// --------------------
	// Duty selection
	// --------------------

	// Named after the low share of the period
	// DUTY_50 is the reset choice
	typedef enum logic [1:0]
	{
		DUTY_10 = 2'd0,
		DUTY_50 = 2'd1,
		DUTY_80 = 2'd2
	} duty_sel_e;

endpackage

// File: include/gpiopwm_macros.svh
// Build constants for the PWM core. Thresholds assume a 32-bit phase word and high-when-above compare
`ifndef GPIOPWM_MACROS_SVH
`define GPIOPWM_MACROS_SVH

// --------------------
// Widths
// --------------------

// Phase accumulator width
`define GPIOPWM_PHASE_W 32

// Number of option keys (right, left, middle)
`define GPIOPWM_KEY_W 3

// --------------------
// Frequency
// --------------------

// fo = fc * step / 2^32
// At 50 MHz one Hz costs about 85.9 steps, so 85899 gives 1 kHz
`define GPIOPWM_STEP_DEFAULT 32'd85899

// --------------------
// Duty thresholds
// --------------------

// Output is high while phase >= threshold, so the name gives the low share
`define GPIOPWM_THR_10 32'd429496729
`define GPIOPWM_THR_50 32'd2147483647
`define GPIOPWM_THR_80 32'd3435973835

// Debounce hold time in clocks (5 ms at 50 MHz)
`define GPIOPWM_DEBOUNCE_DEFAULT 250000

`endif
